// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif grep -q "Simulation completed successfully" $(LOG); then \
		echo "PASS"; \
	else \
		echo "No verdict in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/dcache_bus.sv
`timescale 1ns/1ps

module dcache_bus #(
    parameter int SETS  = 128,
    parameter int WORDS = 16,
    localparam int IDX_W = $clog2(SETS),
    localparam int OFF_W = $clog2(WORDS)
) (
    input  logic                   clk,
    input  logic                   rst,

    // Controller
    input  logic                   fill_valid,
    input  dcache_pkg::fill_cmd_t  fill_cmd,
    output logic                   fill_done,

    // Store
    output logic [IDX_W-1:0]       bus_index,
    output logic [OFF_W-1:0]       bus_offset,
    input  dcache_pkg::word_t      bus_rword,
    output logic                   bus_we,
    output dcache_pkg::word_t      bus_wdata,
    output logic                   line_commit,
    output dcache_pkg::addr_t      commit_tag,

    // Memory
    output dcache_pkg::mem_out_t   mem_out,
    input  dcache_pkg::mem_in_t    mem_in
);

    import dcache_pkg::*;

    localparam int LINE_LSB = OFF_W + 2;
    localparam logic [OFF_W-1:0] LAST_BEAT = OFF_W'(WORDS - 1);

    bus_state_e       state;
    logic [OFF_W-1:0] beat;
    logic             rd_beat;
    logic             wr_beat;

    // Victim and refill share the index in a direct-mapped cache
    assign bus_index  = fill_cmd.fill_addr[LINE_LSB +: IDX_W];
    assign bus_offset = beat;

    assign rd_beat = (state == RF_DATA) && mem_in.rvalid;
    assign wr_beat = (state == WB_DATA) && mem_in.wready;

    assign bus_we      = rd_beat;
    assign bus_wdata   = mem_in.rdata;
    assign line_commit = rd_beat && mem_in.rlast;
    assign commit_tag  = fill_cmd.fill_addr;

    always_comb begin
        mem_out        = '0;
        mem_out.rreq   = (state == RF_ADDR);
        mem_out.raddr  = fill_cmd.fill_addr;
        mem_out.wreq   = (state == WB_ADDR);
        mem_out.waddr  = fill_cmd.victim_addr;
        mem_out.wvalid = (state == WB_DATA);
        mem_out.wdata  = bus_rword;   // Victim word at the current beat
        mem_out.wlast  = (beat == LAST_BEAT);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= B_IDLE;
            beat      <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= line_commit;
            case (state)
                B_IDLE: begin
                    beat <= '0;
                    // fill_valid is still up during the done pulse
                    if (fill_valid && !fill_done) begin
                        state <= fill_cmd.writeback ? WB_ADDR : RF_ADDR;
                    end
                end
                WB_ADDR: begin
                    if (mem_in.wreq_ok) begin
                        state <= WB_DATA;
                    end
                end
                WB_DATA: begin
                    if (wr_beat) begin
                        beat <= beat + 1'b1;  // Wraps to zero after the last
                        if (beat == LAST_BEAT) begin
                            state <= WB_RESP;
                        end
                    end
                end
                WB_RESP: begin
                    if (mem_in.bvalid) begin
                        state <= RF_ADDR;
                    end
                end
                RF_ADDR: begin
                    if (mem_in.rreq_ok) begin
                        state <= RF_DATA;
                    end
                end
                RF_DATA: begin
                    if (rd_beat) begin
                        beat <= beat + 1'b1;
                        if (mem_in.rlast) begin
                            state <= B_IDLE;
                        end
                    end
                end
                default: begin
                    state <= B_IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int SETS  = 128,
    parameter int WORDS = 16,
    localparam int IDX_W = $clog2(SETS),
    localparam int OFF_W = $clog2(WORDS)
) (
    input  logic                   clk,
    input  logic                   rst,

    // CPU side
    input  logic                   cpu_valid,
    input  dcache_pkg::cpu_req_t   cpu_req,
    output logic                   cpu_ok,
    output dcache_pkg::word_t      cpu_rdata,

    // Store lookup and write port
    output logic [IDX_W-1:0]       lookup_index,
    input  dcache_pkg::addr_t      line_tag,
    input  logic                   line_valid,
    input  logic                   line_dirty,
    input  dcache_pkg::word_t      hit_word,
    output logic                   word_we,
    output dcache_pkg::be_t        word_be,
    output dcache_pkg::word_t      word_data,
    output logic [OFF_W-1:0]       word_offset,

    // Bus engine
    output logic                   fill_valid,
    output dcache_pkg::fill_cmd_t  fill_cmd,
    input  logic                   fill_done
);

    import dcache_pkg::*;

    localparam int LINE_LSB = OFF_W + 2;

    ctrl_state_e state;
    cpu_req_t    req_q;
    fill_cmd_t   fill_cmd_q;
    addr_t       req_base;
    logic        hit;

    // Line base of the registered request
    assign req_base = {req_q.addr[31:LINE_LSB], {LINE_LSB{1'b0}}};

    assign lookup_index = req_q.addr[LINE_LSB +: IDX_W];
    assign word_offset  = req_q.addr[2 +: OFF_W];

    // The tag array keeps full line bases, so a plain compare will do
    assign hit = line_valid && (line_tag == req_base);

    assign cpu_ok    = (state == LOOKUP) && hit;
    assign cpu_rdata = hit_word;

    // Write hits merge bytes straight into the store
    assign word_we   = cpu_ok && (|req_q.be);
    assign word_be   = req_q.be;
    assign word_data = req_q.wdata;

    assign fill_valid = (state == MISS_WAIT);
    assign fill_cmd   = fill_cmd_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu_valid) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        state <= IDLE;
                    end else begin
                        state <= MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (fill_done) begin
                        state <= LOOKUP;  // Replay, hits this time
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Request capture
    always_ff @(posedge clk) begin
        if (state == IDLE && cpu_valid) begin
            req_q <= cpu_req;
        end
    end

    // Fill command built from the request and the current occupant
    always_ff @(posedge clk) begin
        if (state == LOOKUP && !hit) begin
            fill_cmd_q.fill_addr   <= req_base;
            fill_cmd_q.victim_addr <= line_tag;
            fill_cmd_q.writeback   <= line_valid && line_dirty;
        end
    end

endmodule

// File: design/dcache_pkg.sv
package dcache_pkg;

    // Plain vector types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_t;     // All zero on a read

    // One CPU access, held by the CPU until cpu_ok
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        be_t   be;
    } cpu_req_t;

    // Line-fill command, controller to bus engine
    typedef struct packed {
        addr_t fill_addr;     // Line base to refill
        addr_t victim_addr;   // Line base of the current occupant
        logic  writeback;     // Victim is dirty
    } fill_cmd_t;

    // Bus engine to memory
    typedef struct packed {
        logic  rreq;
        addr_t raddr;
        logic  wreq;
        addr_t waddr;
        logic  wvalid;
        word_t wdata;
        logic  wlast;
    } mem_out_t;

    // Memory to bus engine
    typedef struct packed {
        logic  rreq_ok;
        logic  wreq_ok;
        logic  rvalid;
        word_t rdata;
        logic  rlast;
        logic  wready;
        logic  bvalid;
    } mem_in_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS_WAIT
    } ctrl_state_e;

    typedef enum logic [2:0] {
        B_IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP,
        RF_ADDR,
        RF_DATA
    } bus_state_e;

endpackage

// File: design/dcache_store.sv
`timescale 1ns/1ps

module dcache_store #(
    parameter int SETS  = 128,
    parameter int WORDS = 16,
    localparam int IDX_W = $clog2(SETS),
    localparam int OFF_W = $clog2(WORDS)
) (
    input  logic                   clk,
    input  logic                   rst,

    // Controller port
    input  logic [IDX_W-1:0]       lookup_index,
    input  logic [OFF_W-1:0]       word_offset,
    output dcache_pkg::addr_t      line_tag,
    output logic                   line_valid,
    output logic                   line_dirty,
    output dcache_pkg::word_t      hit_word,
    input  logic                   word_we,
    input  dcache_pkg::be_t        word_be,
    input  dcache_pkg::word_t      word_data,

    // Bus engine port
    input  logic [IDX_W-1:0]       bus_index,
    input  logic [OFF_W-1:0]       bus_offset,
    output dcache_pkg::word_t      bus_rword,
    input  logic                   bus_we,
    input  dcache_pkg::word_t      bus_wdata,
    input  logic                   line_commit,
    input  dcache_pkg::addr_t      commit_tag
);

    import dcache_pkg::*;

    localparam int DEPTH = SETS * WORDS;

    addr_t            tag_mem [SETS];
    word_t            data_mem [DEPTH];
    logic [SETS-1:0]  valid_bits;
    logic [SETS-1:0]  dirty_bits;

    logic [IDX_W+OFF_W-1:0] ctrl_waddr;
    logic [IDX_W+OFF_W-1:0] bus_waddr;

    // Word address is index then offset
    assign ctrl_waddr = {lookup_index, word_offset};
    assign bus_waddr  = {bus_index, bus_offset};

    // Both read ports are combinational
    assign line_tag   = tag_mem[lookup_index];
    assign line_valid = valid_bits[lookup_index];
    assign line_dirty = dirty_bits[lookup_index];
    assign hit_word   = data_mem[ctrl_waddr];
    assign bus_rword  = data_mem[bus_waddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (line_commit) begin
            valid_bits[bus_index] <= 1'b1;
            dirty_bits[bus_index] <= 1'b0;  // Fresh line from memory
        end else if (word_we) begin
            dirty_bits[lookup_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line_commit) begin
            tag_mem[bus_index] <= commit_tag;
        end
    end

    // Controller and bus never write in the same cycle
    always_ff @(posedge clk) begin
        if (word_we) begin
            for (int b = 0; b < 4; b++) begin
                if (word_be[b]) begin
                    data_mem[ctrl_waddr][8*b +: 8] <= word_data[8*b +: 8];
                end
            end
        end else if (bus_we) begin
            data_mem[bus_waddr] <= bus_wdata;
        end
    end

endmodule

// File: design/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int SETS  = 128,
    parameter int WORDS = 16,
    localparam int IDX_W = $clog2(SETS),
    localparam int OFF_W = $clog2(WORDS)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_valid,
    input  dcache_pkg::cpu_req_t   cpu_req,
    output logic                   cpu_ok,
    output dcache_pkg::word_t      cpu_rdata,
    output dcache_pkg::mem_out_t   mem_out,
    input  dcache_pkg::mem_in_t    mem_in
);

    import dcache_pkg::*;

    // Controller to store
    logic [IDX_W-1:0] lookup_index;
    logic [OFF_W-1:0] word_offset;
    addr_t            line_tag;
    logic             line_valid;
    logic             line_dirty;
    word_t            hit_word;
    logic             word_we;
    be_t              word_be;
    word_t            word_data;

    // Controller to bus engine
    logic             fill_valid;
    fill_cmd_t        fill_cmd;
    logic             fill_done;

    // Bus engine to store
    logic [IDX_W-1:0] bus_index;
    logic [OFF_W-1:0] bus_offset;
    word_t            bus_rword;
    logic             bus_we;
    word_t            bus_wdata;
    logic             line_commit;
    addr_t            commit_tag;

    dcache_ctrl #(
        .SETS  (SETS),
        .WORDS (WORDS)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_valid    (cpu_valid),
        .cpu_req      (cpu_req),
        .cpu_ok       (cpu_ok),
        .cpu_rdata    (cpu_rdata),
        .lookup_index (lookup_index),
        .line_tag     (line_tag),
        .line_valid   (line_valid),
        .line_dirty   (line_dirty),
        .hit_word     (hit_word),
        .word_we      (word_we),
        .word_be      (word_be),
        .word_data    (word_data),
        .word_offset  (word_offset),
        .fill_valid   (fill_valid),
        .fill_cmd     (fill_cmd),
        .fill_done    (fill_done)
    );

    dcache_store #(
        .SETS  (SETS),
        .WORDS (WORDS)
    ) u_store (
        .clk          (clk),
        .rst          (rst),
        .lookup_index (lookup_index),
        .word_offset  (word_offset),
        .line_tag     (line_tag),
        .line_valid   (line_valid),
        .line_dirty   (line_dirty),
        .hit_word     (hit_word),
        .word_we      (word_we),
        .word_be      (word_be),
        .word_data    (word_data),
        .bus_index    (bus_index),
        .bus_offset   (bus_offset),
        .bus_rword    (bus_rword),
        .bus_we       (bus_we),
        .bus_wdata    (bus_wdata),
        .line_commit  (line_commit),
        .commit_tag   (commit_tag)
    );

    dcache_bus #(
        .SETS  (SETS),
        .WORDS (WORDS)
    ) u_bus (
        .clk          (clk),
        .rst          (rst),
        .fill_valid   (fill_valid),
        .fill_cmd     (fill_cmd),
        .fill_done    (fill_done),
        .bus_index    (bus_index),
        .bus_offset   (bus_offset),
        .bus_rword    (bus_rword),
        .bus_we       (bus_we),
        .bus_wdata    (bus_wdata),
        .line_commit  (line_commit),
        .commit_tag   (commit_tag),
        .mem_out      (mem_out),
        .mem_in       (mem_in)
    );

endmodule

// File: dv/dcache_mem_model.sv
`timescale 1ns/1ps

module dcache_mem_model #(
    parameter int WORDS = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::mem_out_t  mem_out,
    output dcache_pkg::mem_in_t   mem_in
);

    import dcache_pkg::*;

    typedef enum logic [1:0] {
        M_IDLE,
        M_READ,
        M_WDATA,
        M_WRESP
    } mem_state_e;

    mem_state_e state;
    word_t      mem_words [addr_t];  // Written words only, keyed by word address
    addr_t      base;
    int         beat;
    int         stall;

    function automatic word_t init_word(addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t read_word(addr_t a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return init_word(a);
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            state  <= M_IDLE;
            mem_in <= '0;
            beat   <= 0;
            stall  <= $urandom_range(0, 3);
        end else begin
            // Single-cycle pulses
            mem_in.rreq_ok <= 1'b0;
            mem_in.wreq_ok <= 1'b0;
            mem_in.rvalid  <= 1'b0;
            mem_in.rlast   <= 1'b0;
            mem_in.bvalid  <= 1'b0;
            case (state)
                M_IDLE: begin
                    beat <= 0;
                    if (mem_out.rreq || mem_out.wreq) begin
                        if (stall > 0) begin
                            stall <= stall - 1;
                        end else if (mem_out.rreq) begin
                            mem_in.rreq_ok <= 1'b1;
                            base  <= mem_out.raddr;
                            state <= M_READ;
                            stall <= $urandom_range(0, 3);
                        end else begin
                            mem_in.wreq_ok <= 1'b1;
                            base  <= mem_out.waddr;
                            state <= M_WDATA;
                            stall <= $urandom_range(0, 3);
                        end
                    end
                end
                M_READ: begin
                    if (stall > 0) begin
                        stall <= stall - 1;
                    end else begin
                        mem_in.rvalid <= 1'b1;
                        mem_in.rdata  <= read_word(base + addr_t'(4 * beat));
                        mem_in.rlast  <= (beat == WORDS - 1);
                        beat  <= beat + 1;
                        stall <= $urandom_range(0, 3);
                        if (beat == WORDS - 1) begin
                            state <= M_IDLE;
                        end
                    end
                end
                M_WDATA: begin
                    if (mem_in.wready && mem_out.wvalid) begin
                        mem_words[base + addr_t'(4 * beat)] = mem_out.wdata;
                        mem_in.wready <= 1'b0;
                        stall <= $urandom_range(0, 3);
                        beat  <= beat + 1;
                        if (beat == WORDS - 1) begin
                            state <= M_WRESP;
                        end
                    end else if (stall > 0) begin
                        stall <= stall - 1;
                    end else if (mem_out.wvalid) begin
                        mem_in.wready <= 1'b1;
                    end
                end
                M_WRESP: begin
                    if (stall > 0) begin
                        stall <= stall - 1;
                    end else begin
                        mem_in.bvalid <= 1'b1;
                        state <= M_IDLE;
                        stall <= $urandom_range(0, 3);
                    end
                end
                default: begin
                    state <= M_IDLE;
                end
            endcase
        end
    end

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    import dcache_pkg::*;

    localparam int SETS     = 128;
    localparam int WORDS    = 16;
    localparam int LINE_LSB = $clog2(WORDS) + 2;
    localparam int IDX_W    = $clog2(SETS);
    localparam int PERIOD   = 100;
    localparam int N_COLD   = 24;
    localparam int N_MERGE  = 16;
    localparam int N_EVICT  = 12;
    localparam int N_RANDOM = 400;
    localparam int N_OPS    = N_COLD + N_MERGE + N_EVICT + N_RANDOM;
    localparam longint LIMIT_CYCLES = longint'(N_OPS) * (4 * WORDS * 4 + 20);

    logic     clk;
    logic     rst;
    logic     cpu_valid;
    cpu_req_t cpu_req;
    logic     cpu_ok;
    word_t    cpu_rdata;
    mem_out_t mem_out;
    mem_in_t  mem_in;

    // Reference memory and expected cache occupancy
    word_t shadow [addr_t];
    addr_t ref_base [SETS];
    logic  ref_valid [SETS];
    logic  ref_dirty [SETS];

    // Bus traffic expected for the access in flight
    logic  exp_refill;
    logic  exp_wb;
    addr_t exp_fill_addr;
    addr_t exp_victim_addr;
    int    wb_beat;
    int    wb_count;

    string exp_name_q [$];
    word_t exp_data_q [$];
    logic  exp_read_q [$];
    logic  ok_prev;  // cpu_ok at the previous falling edge

    dcache_top DUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .cpu_ok    (cpu_ok),
        .cpu_rdata (cpu_rdata),
        .mem_out   (mem_out),
        .mem_in    (mem_in)
    );

    dcache_mem_model #(
        .WORDS (WORDS)
    ) u_mem (
        .clk     (clk),
        .rst     (rst),
        .mem_out (mem_out),
        .mem_in  (mem_in)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic word_t init_word(addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t expected_read(addr_t a);
        addr_t w;
        w = {a[31:2], 2'b00};
        if (shadow.exists(w)) begin
            return shadow[w];
        end
        return init_word(w);
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t data, be_t be);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic access(string name, addr_t addr, word_t wdata, be_t be);
        int    idx;
        int    waits;
        addr_t base;
        addr_t waddr;
        logic  miss;
        waddr = {addr[31:2], 2'b00};
        base  = {addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
        idx   = int'(addr[LINE_LSB +: IDX_W]);
        miss  = !(ref_valid[idx] && ref_base[idx] == base);
        if (miss) begin
            exp_refill      = 1'b1;
            exp_fill_addr   = base;
            exp_wb          = ref_valid[idx] && ref_dirty[idx];
            exp_victim_addr = ref_base[idx];
        end
        exp_name_q.push_back(name);
        exp_data_q.push_back(expected_read(waddr));
        exp_read_q.push_back(be == 4'b0000);
        cpu_valid     = 1'b1;
        cpu_req.addr  = waddr;
        cpu_req.wdata = wdata;
        cpu_req.be    = be;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!cpu_ok);
        if (exp_refill) begin
            report_failure($sformatf("%s missed but no refill request was accepted", name));
        end
        if (exp_wb) begin
            report_failure($sformatf("%s evicted a dirty line without a write-back", name));
        end
        // Capture at the first edge, hit answered in the next cycle
        if (!miss && waits != 2) begin
            report_failure($sformatf("%s hit was not answered in the cycle after capture",
                                     name));
        end
        if (be != 4'b0000) begin
            shadow[waddr] = merge_bytes(expected_read(waddr), wdata, be);
        end
        if (miss) begin
            ref_dirty[idx] = 1'b0;
        end
        ref_base[idx]  = base;
        ref_valid[idx] = 1'b1;
        ref_dirty[idx] = ref_dirty[idx] || (be != 4'b0000);
        @(posedge clk);
        #1;
        cpu_valid = 1'b0;
    endtask

    // CPU results in request order
    always @(negedge clk) begin
        string name;
        word_t exp;
        logic  is_read;
        if (!rst && cpu_ok) begin
            if (ok_prev) begin
                report_failure("cpu_ok stayed high for a second cycle on one request");
            end
            if (exp_name_q.size() == 0) begin
                report_failure("cpu_ok pulsed with no request outstanding");
            end
            name    = exp_name_q.pop_front();
            exp     = exp_data_q.pop_front();
            is_read = exp_read_q.pop_front();
            if (is_read) begin
                check_word(name, exp, cpu_rdata);
            end
        end
        ok_prev = cpu_ok;
    end

    // Memory side traffic
    always @(negedge clk) begin
        if (!rst) begin
            if (mem_out.rreq && mem_in.rreq_ok) begin
                if (!exp_refill) begin
                    report_failure("refill request accepted with no miss outstanding");
                end
                check_addr("refill address", exp_fill_addr, mem_out.raddr);
                exp_refill = 1'b0;
            end
            if (mem_out.wreq && mem_in.wreq_ok) begin
                if (!exp_wb) begin
                    report_failure("write-back request accepted with no dirty victim");
                end
                check_addr("write-back address", exp_victim_addr, mem_out.waddr);
                exp_wb  = 1'b0;
                wb_beat = 0;
                wb_count++;
            end
            if (mem_out.wvalid && mem_in.wready) begin
                check_word($sformatf("write-back word %0d", wb_beat),
                           expected_read(exp_victim_addr + addr_t'(4 * wb_beat)),
                           mem_out.wdata);
                if (mem_out.wlast != (wb_beat == WORDS - 1)) begin
                    report_failure($sformatf("wlast wrong on write-back beat %0d", wb_beat));
                end
                wb_beat++;
            end
            if (mem_in.bvalid && wb_beat != WORDS) begin
                report_failure("write response arrived before the last write-back beat");
            end
        end
    end

    initial begin
        #(LIMIT_CYCLES * PERIOD);
        report_failure($sformatf("Run did not finish within %0d cycles", LIMIT_CYCLES));
    end

    initial begin
        addr_t a;
        addr_t b;
        int    wb_before;
        void'($urandom(54));
        cpu_valid  = 1'b0;
        cpu_req    = '0;
        rst        = 1'b1;
        exp_refill = 1'b0;
        exp_wb     = 1'b0;
        wb_beat    = 0;
        wb_count   = 0;
        ok_prev    = 1'b0;
        for (int i = 0; i < SETS; i++) begin
            ref_base[i]  = '0;
            ref_valid[i] = 1'b0;
            ref_dirty[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reads of untouched lines
        for (int i = 0; i < N_COLD; i++) begin
            a = 32'h0001_0000 + addr_t'(i) * 32'h148;
            access($sformatf("cold read %0d", i), a, '0, 4'b0000);
        end

        // Repeated partial writes to three words
        for (int i = 0; i < N_MERGE / 2; i++) begin
            a = 32'h0002_0100 + addr_t'(4 * (i % 3));
            access($sformatf("merge write %0d", i), a, $urandom(), be_t'(i * 7 + 1));
            access($sformatf("merge read %0d", i), a, '0, 4'b0000);
        end

        // Dirty line evicted by a line with the same index
        for (int r = 0; r < N_EVICT / 4; r++) begin
            a = 32'h0003_0000 + addr_t'(r) * 32'h844;
            b = a + addr_t'(r + 1) * 32'h2000;
            access($sformatf("evict write A %0d", r), a, $urandom(), 4'b1111);
            wb_before = wb_count;
            access($sformatf("evict read B %0d", r), b, '0, 4'b0000);
            if (wb_count != wb_before + 1) begin
                report_failure($sformatf("eviction round %0d gave no write-back", r));
            end
            access($sformatf("evict read A %0d", r), a, '0, 4'b0000);
            access($sformatf("evict reread B %0d", r), b, '0, 4'b0000);
        end

        // Random traffic over four indices and four tags
        for (int i = 0; i < N_RANDOM; i++) begin
            a = addr_t'($urandom_range(1, 4)) * 32'h2000
                + addr_t'($urandom_range(0, 3) * 37) * 32'h40
                + addr_t'($urandom_range(0, WORDS - 1)) * 4;
            if ($urandom_range(0, 1) == 0) begin
                access($sformatf("random read %0d", i), a, '0, 4'b0000);
            end else begin
                access($sformatf("random write %0d", i), a, $urandom(),
                       be_t'($urandom_range(1, 15)));
            end
        end

        repeat (2) @(posedge clk);
        if (exp_name_q.size() != 0) begin
            report_failure("requests still outstanding at the end of the run");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: vlog.f
design/dcache_pkg.sv
design/dcache_ctrl.sv
design/dcache_store.sv
design/dcache_bus.sv
design/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv
